//--- all.f
vc_router_pkg.sv
rr_arbiter.sv
vc_input_port.sv
vc_output_alloc.sv
vc_switch.sv
vc_router.sv
vc_router_assertions.sv
vc_router_tb.sv

//--- rr_arbiter.sv
/*
 * round-robin arbiter with a rotating priority pointer
 * serves both the local and the global switch allocators
 */

`timescale 1ns/1ps

module rr_arbiter #(
  parameter int NumReq = 2
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic [NumReq-1:0] req_i,
  input  logic              update_i,
  output logic [NumReq-1:0] grant_oh_o,
  output logic              valid_o
);

  localparam int IdxWidth = (NumReq > 1) ? $clog2(NumReq) : 1;

  logic [IdxWidth-1:0] ptr_q;
  logic [IdxWidth-1:0] grant_idx;

  // first request at or after the pointer, wrapping around
  always_comb begin
    int   idx;
    logic found;
    idx        = 0;
    found      = 1'b0;
    grant_oh_o = '0;
    grant_idx  = '0;
    for (int i = 0; i < NumReq; i++) begin
      idx = (int'(ptr_q) + i) % NumReq;
      if (!found && req_i[idx]) begin
        found           = 1'b1;
        grant_oh_o[idx] = 1'b1;
        grant_idx       = IdxWidth'(idx);
      end
    end
    valid_o = found;
  end

  // winner gets lowest priority next time
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= '0;
    end else if (update_i && valid_o) begin
      if (int'(grant_idx) == NumReq - 1) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= grant_idx + 1'b1;
      end
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# build the vc router testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module vc_router_tb -f all.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vvc_router_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "^TEST PASSED$"; then
  exit 0
fi
exit 1

//--- vc_input_port.sv
/*
 * one router input port
 * per-vc circular flit fifos, local switch allocation over the vc heads
 * and the registered credit return towards the upstream sender
 */

`timescale 1ns/1ps

module vc_input_port #(
  parameter int NumPorts = vc_router_pkg::DefaultNumPorts,
  parameter int NumVc    = vc_router_pkg::DefaultNumVc,
  parameter int VcDepth  = vc_router_pkg::DefaultVcDepth
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  data_v_i,
  input  vc_router_pkg::flit_t  data_i,
  input  logic                  pop_i,
  output logic                  req_valid_o,
  output vc_router_pkg::flit_t  req_flit_o,
  output logic                  credit_v_o,
  output vc_router_pkg::vc_id_t credit_id_o
);

  localparam int PtrWidth = (VcDepth > 1) ? $clog2(VcDepth) : 1;
  localparam int CntWidth = $clog2(VcDepth + 1);

  typedef struct packed {
    logic [PtrWidth-1:0] wr_ptr;
    logic [PtrWidth-1:0] rd_ptr;
    logic [CntWidth-1:0] count;
  } fifo_state_t;

  vc_router_pkg::flit_t  mem_q [NumVc][VcDepth];
  fifo_state_t [NumVc-1:0] fifo_q;
  logic [NumVc-1:0]      push;
  logic [NumVc-1:0]      pop;
  logic [NumVc-1:0]      not_empty;
  logic [NumVc-1:0]      sel_oh;
  logic                  sel_valid;
  vc_router_pkg::vc_id_t sel_vc;

  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    if (int'(ptr) == VcDepth - 1) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ==========================================================================
  // per-vc fifos
  // ==========================================================================

  for (genvar v = 0; v < NumVc; v++) begin : gen_vc
    // incoming flit is steered by its own vc field
    assign push[v]      = data_v_i && (int'(data_i.vc) == v);
    assign pop[v]       = pop_i && sel_oh[v];
    assign not_empty[v] = (fifo_q[v].count != '0);
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fifo_q <= '0;
    end else begin
      for (int v = 0; v < NumVc; v++) begin
        if (push[v]) begin
          fifo_q[v].wr_ptr <= next_ptr(fifo_q[v].wr_ptr);
        end
        if (pop[v]) begin
          fifo_q[v].rd_ptr <= next_ptr(fifo_q[v].rd_ptr);
        end
        fifo_q[v].count <= fifo_q[v].count + CntWidth'(push[v]) - CntWidth'(pop[v]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int v = 0; v < NumVc; v++) begin
      if (push[v]) begin
        mem_q[v][fifo_q[v].wr_ptr] <= data_i;
      end
    end
  end

  // ==========================================================================
  // local switch allocation
  // ==========================================================================

  // pointer only moves on a pop, so a blocked winner stays the winner
  rr_arbiter #(
    .NumReq     (NumVc)
  ) u_local_sa (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .req_i      (not_empty),
    .update_i   (pop_i),
    .grant_oh_o (sel_oh),
    .valid_o    (sel_valid)
  );

  always_comb begin
    sel_vc = '0;
    for (int v = 0; v < NumVc; v++) begin
      if (sel_oh[v]) begin
        sel_vc = vc_router_pkg::vc_id_t'(v);
      end
    end
  end

  assign req_flit_o  = mem_q[sel_vc][fifo_q[sel_vc].rd_ptr];
  // only outputs that exist may be requested
  assign req_valid_o = sel_valid && (int'(req_flit_o.dst_port) < NumPorts);

  // credit leaves together with the flit in the st stage
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_v_o  <= 1'b0;
      credit_id_o <= '0;
    end else begin
      credit_v_o  <= pop_i;
      credit_id_o <= sel_vc;
    end
  end

endmodule

//--- vc_output_alloc.sv
/*
 * allocation for one router output
 * downstream credit counters, lowest-free vc selection,
 * global switch allocation over the inputs and vc assignment
 */

`timescale 1ns/1ps

module vc_output_alloc #(
  parameter int NumPorts = vc_router_pkg::DefaultNumPorts,
  parameter int NumVc    = vc_router_pkg::DefaultNumVc,
  parameter int VcDepth  = vc_router_pkg::DefaultVcDepth
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic [NumPorts-1:0]   req_i,
  input  logic                  credit_v_i,
  input  vc_router_pkg::vc_id_t credit_id_i,
  output logic [NumPorts-1:0]   grant_oh_o,
  output vc_router_pkg::vc_id_t assigned_vc_o
);

  localparam int CntWidth = $clog2(VcDepth + 1);

  logic [NumVc-1:0][CntWidth-1:0] credit_q;
  logic [NumVc-1:0]               credit_inc;
  logic [NumVc-1:0]               credit_dec;
  logic                           vc_free;
  logic [NumPorts-1:0]            req_masked;
  logic                           grant_v;

  // ==========================================================================
  // vc selection
  // ==========================================================================

  // scan downwards so the lowest vc with credit wins
  always_comb begin
    vc_free       = 1'b0;
    assigned_vc_o = '0;
    for (int v = NumVc - 1; v >= 0; v--) begin
      if (credit_q[v] != '0) begin
        vc_free       = 1'b1;
        assigned_vc_o = vc_router_pkg::vc_id_t'(v);
      end
    end
  end

  // ==========================================================================
  // global switch allocation
  // ==========================================================================

  // no downstream space means nobody is granted and the pointer holds
  assign req_masked = req_i & {NumPorts{vc_free}};

  rr_arbiter #(
    .NumReq     (NumPorts)
  ) u_global_sa (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .req_i      (req_masked),
    .update_i   (grant_v),
    .grant_oh_o (grant_oh_o),
    .valid_o    (grant_v)
  );

  // ==========================================================================
  // credit counters
  // ==========================================================================

  for (genvar v = 0; v < NumVc; v++) begin : gen_credit
    assign credit_dec[v] = grant_v && (int'(assigned_vc_o) == v);
    assign credit_inc[v] = credit_v_i && (int'(credit_id_i) == v);
  end

  // spend and return can hit the same vc in one cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int v = 0; v < NumVc; v++) begin
        credit_q[v] <= CntWidth'(VcDepth);
      end
    end else begin
      for (int v = 0; v < NumVc; v++) begin
        credit_q[v] <= credit_q[v] + CntWidth'(credit_inc[v]) - CntWidth'(credit_dec[v]);
      end
    end
  end

endmodule

//--- vc_router.sv
/*
 * input-queued virtual-channel router, top level
 * input ports, output allocators, switch, and the mapping
 * between per-input and per-output space
 */

`timescale 1ns/1ps

module vc_router #(
  parameter int NumPorts = vc_router_pkg::DefaultNumPorts,
  parameter int NumVc    = vc_router_pkg::DefaultNumVc,
  parameter int VcDepth  = vc_router_pkg::DefaultVcDepth
) (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  // upstream side
  input  logic [NumPorts-1:0]                  data_v_i,
  input  vc_router_pkg::flit_t [NumPorts-1:0]  data_i,
  output logic [NumPorts-1:0]                  credit_v_o,
  output vc_router_pkg::vc_id_t [NumPorts-1:0] credit_id_o,
  // downstream side
  output logic [NumPorts-1:0]                  data_v_o,
  output vc_router_pkg::flit_t [NumPorts-1:0]  data_o,
  input  logic [NumPorts-1:0]                  credit_v_i,
  input  vc_router_pkg::vc_id_t [NumPorts-1:0] credit_id_i
);

  logic [NumPorts-1:0]                  req_valid;
  vc_router_pkg::flit_t [NumPorts-1:0]  req_flit;
  logic [NumPorts-1:0]                  pop;
  // [out][in] and its transpose [in][out]
  logic [NumPorts-1:0][NumPorts-1:0]    req_per_output;
  logic [NumPorts-1:0][NumPorts-1:0]    grant_per_output;
  logic [NumPorts-1:0][NumPorts-1:0]    grant_per_input;
  vc_router_pkg::vc_id_t [NumPorts-1:0] assigned_vc;

  // ==========================================================================
  // input ports and output allocators
  // ==========================================================================

  for (genvar p = 0; p < NumPorts; p++) begin : gen_ports
    vc_input_port #(
      .NumPorts    (NumPorts),
      .NumVc       (NumVc),
      .VcDepth     (VcDepth)
    ) u_input_port (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .data_v_i    (data_v_i[p]),
      .data_i      (data_i[p]),
      .pop_i       (pop[p]),
      .req_valid_o (req_valid[p]),
      .req_flit_o  (req_flit[p]),
      .credit_v_o  (credit_v_o[p]),
      .credit_id_o (credit_id_o[p])
    );

    vc_output_alloc #(
      .NumPorts      (NumPorts),
      .NumVc         (NumVc),
      .VcDepth       (VcDepth)
    ) u_output_alloc (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .req_i         (req_per_output[p]),
      .credit_v_i    (credit_v_i[p]),
      .credit_id_i   (credit_id_i[p]),
      .grant_oh_o    (grant_per_output[p]),
      .assigned_vc_o (assigned_vc[p])
    );
  end

  // ==========================================================================
  // input space to output space and back
  // ==========================================================================

  for (genvar o = 0; o < NumPorts; o++) begin : gen_map_out
    for (genvar i = 0; i < NumPorts; i++) begin : gen_map_in
      // source routing, the header names the output
      assign req_per_output[o][i] =
          req_valid[i] && (req_flit[i].dst_port == vc_router_pkg::port_id_t'(o));
      assign grant_per_input[i][o] = grant_per_output[o][i];
    end
  end

  // an input wins at most one output since it requests only one
  for (genvar p = 0; p < NumPorts; p++) begin : gen_pop
    assign pop[p] = |grant_per_input[p];
  end

  vc_switch #(
    .NumPorts      (NumPorts)
  ) u_switch (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .grant_oh_i    (grant_per_output),
    .assigned_vc_i (assigned_vc),
    .flits_i       (req_flit),
    .data_v_o      (data_v_o),
    .data_o        (data_o)
  );

endmodule

//--- vc_router_assertions.sv
/*
 * concurrent assertions bound to the vc router
 * loopback, fifo overflow, downstream credit bound, one-hot grants
 */

`timescale 1ns/1ps

module vc_router_assertions #(
  parameter int NumPorts = vc_router_pkg::DefaultNumPorts,
  parameter int NumVc    = vc_router_pkg::DefaultNumVc,
  parameter int VcDepth  = vc_router_pkg::DefaultVcDepth
) (
  input logic                                 clk_i,
  input logic                                 arst_n_i,
  input logic [NumPorts-1:0]                  data_v_i,
  input vc_router_pkg::flit_t [NumPorts-1:0]  data_i,
  input logic [NumPorts-1:0]                  credit_v_o,
  input vc_router_pkg::vc_id_t [NumPorts-1:0] credit_id_o,
  input logic [NumPorts-1:0]                  data_v_o,
  input vc_router_pkg::flit_t [NumPorts-1:0]  data_o,
  input logic [NumPorts-1:0]                  credit_v_i,
  input vc_router_pkg::vc_id_t [NumPorts-1:0] credit_id_i,
  input logic [NumPorts-1:0][NumPorts-1:0]    grant_per_output
);

  // fifo fill as seen through the credit loop is never below the real fill
  int occ_q [NumPorts][NumVc];
  // downstream credits as seen on the output ports
  int ds_q  [NumPorts][NumVc];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int p = 0; p < NumPorts; p++) begin
        for (int v = 0; v < NumVc; v++) begin
          occ_q[p][v] <= 0;
          ds_q[p][v]  <= VcDepth;
        end
      end
    end else begin
      for (int p = 0; p < NumPorts; p++) begin
        for (int v = 0; v < NumVc; v++) begin
          occ_q[p][v] <= occ_q[p][v] + int'(data_v_i[p] && int'(data_i[p].vc) == v)
                         - int'(credit_v_o[p] && int'(credit_id_o[p]) == v);
          ds_q[p][v]  <= ds_q[p][v] + int'(credit_v_i[p] && int'(credit_id_i[p]) == v)
                         - int'(data_v_o[p] && int'(data_o[p].vc) == v);
        end
      end
    end
  end

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port_chk
    a_no_loopback : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        data_v_i[p] |-> data_i[p].dst_port != vc_router_pkg::port_id_t'(p))
      else $error("flit on input %0d names its own port as destination", p);

    a_grant_onehot : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0(grant_per_output[p]))
      else $error("output %0d grants more than one input", p);

    for (genvar v = 0; v < NumVc; v++) begin : gen_vc_chk
      a_no_overflow : assert property (@(posedge clk_i) disable iff (!arst_n_i)
          (data_v_i[p] && int'(data_i[p].vc) == v) |->
          occ_q[p][v] - int'(credit_v_o[p] && int'(credit_id_o[p]) == v) < VcDepth)
        else $error("input %0d vc %0d written while full", p, v);

      // a flit may only leave on a vc that still holds a downstream credit
      a_credit_bound : assert property (@(posedge clk_i) disable iff (!arst_n_i)
          (data_v_o[p] && int'(data_o[p].vc) == v) |-> ds_q[p][v] > 0)
        else $error("output %0d vc %0d sent without downstream credit", p, v);
    end
  end

endmodule

bind vc_router vc_router_assertions #(
  .NumPorts         (NumPorts),
  .NumVc            (NumVc),
  .VcDepth          (VcDepth)
) u_assertions (
  .clk_i            (clk_i),
  .arst_n_i         (arst_n_i),
  .data_v_i         (data_v_i),
  .data_i           (data_i),
  .credit_v_o       (credit_v_o),
  .credit_id_o      (credit_id_o),
  .data_v_o         (data_v_o),
  .data_o           (data_o),
  .credit_v_i       (credit_v_i),
  .credit_id_i      (credit_id_i),
  .grant_per_output (grant_per_output)
);

//--- vc_router_pkg.sv
/*
 * shared widths and types of the vc router
 * flit struct with source-routed header, parameter defaults
 */

package vc_router_pkg;

  // ==========================================================================
  // widths
  // ==========================================================================

  // up to four ports and two vcs
  localparam int PortIdWidth  = 2;
  localparam int VcIdWidth    = 1;
  localparam int PayloadWidth = 16;

  typedef logic [PortIdWidth-1:0] port_id_t;
  typedef logic [VcIdWidth-1:0]   vc_id_t;

  // single-flit packet, output port carried in the header
  typedef struct packed {
    port_id_t                dst_port;
    // input vc on arrival, downstream vc on departure
    vc_id_t                  vc;
    logic [PayloadWidth-1:0] payload;
  } flit_t;

  // ==========================================================================
  // defaults for the top level
  // ==========================================================================

  localparam int DefaultNumPorts = 4;
  localparam int DefaultNumVc    = 2;
  // fifo depth per vc, also the initial credit count
  localparam int DefaultVcDepth  = 2;

endpackage

//--- vc_router_tb.sv
/*
 * testbench for the vc router
 * clock, stimulus, upstream and downstream credit models,
 * reference flit function and the scoreboard
 */

`timescale 1ns/1ps

module vc_router_tb;

  localparam int NumPorts = vc_router_pkg::DefaultNumPorts;
  localparam int NumVc    = vc_router_pkg::DefaultNumVc;
  localparam int VcDepth  = vc_router_pkg::DefaultVcDepth;
  localparam int Timeout  = 2000;

  logic                                 clk_i;
  logic                                 arst_n_i;
  logic [NumPorts-1:0]                  data_v_i;
  vc_router_pkg::flit_t [NumPorts-1:0]  data_i;
  logic [NumPorts-1:0]                  credit_v_o;
  vc_router_pkg::vc_id_t [NumPorts-1:0] credit_id_o;
  logic [NumPorts-1:0]                  data_v_o;
  vc_router_pkg::flit_t [NumPorts-1:0]  data_o;
  logic [NumPorts-1:0]                  credit_v_i;
  vc_router_pkg::vc_id_t [NumPorts-1:0] credit_id_i;

  // free upstream slots per vc are VcDepth - sent + returned
  int sent     [NumPorts][NumVc];
  int returned [NumPorts][NumVc];
  int seq_cnt  [NumPorts][NumVc];
  // expected sequence numbers per source, vc and destination
  int exp_q    [NumPorts][NumVc][NumPorts][$];
  // monitor cycle at which the router took each payload
  int in_time  [int];
  int ds_pend  [NumPorts][$];
  int ds_cred  [NumPorts][NumVc];
  int vc_log   [NumPorts][$];
  int out_cnt  [NumPorts];
  int last_lat [NumPorts];
  int last_src [NumPorts];
  int cyc;
  int total_sent;
  int total_recv;
  logic [NumPorts-1:0] hold;
  logic jitter;
  logic fair_mode;

  vc_router #(
    .NumPorts    (NumPorts),
    .NumVc       (NumVc),
    .VcDepth     (VcDepth)
  ) vc_router_inst (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .data_v_i    (data_v_i),
    .data_i      (data_i),
    .credit_v_o  (credit_v_o),
    .credit_id_o (credit_id_o),
    .data_v_o    (data_v_o),
    .data_o      (data_o),
    .credit_v_i  (credit_v_i),
    .credit_id_i (credit_id_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // payload packs source port, source vc and sequence number
  function automatic vc_router_pkg::flit_t expected_flit(input int src, input int vc,
                                                         input int seq, input int dst);
    vc_router_pkg::flit_t f;
    f.dst_port = vc_router_pkg::port_id_t'(dst);
    f.vc       = vc_router_pkg::vc_id_t'(vc);
    f.payload  = {2'(src), 1'(vc), 13'(seq)};
    return f;
  endfunction

  task automatic report_failure(input string what);
    $display("[ERROR] %0t %s", $time, what);
    $display("TEST FAILED");
    $fatal(1, "testbench stopped");
  endtask

  task automatic check_value(input string name, input longint actual, input longint expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // ==========================================================================
  // monitor, scoreboard and downstream credit model
  // ==========================================================================

  initial begin
    int src;
    int vc;
    int key;
    int arr_src [NumPorts];
    vc_router_pkg::flit_t exp;
    credit_v_i  = '0;
    credit_id_i = '0;
    forever begin
      @(posedge clk_i);
      if (arst_n_i) begin
        cyc++;
        for (int p = 0; p < NumPorts; p++) begin
          arr_src[p] = 0;
          if (data_v_i[p]) begin
            in_time[int'(data_i[p].payload)] = cyc;
          end
          if (credit_v_o[p]) begin
            returned[p][credit_id_o[p]]++;
            check_value("upstream credits outstanding",
                        returned[p][credit_id_o[p]] <= sent[p][credit_id_o[p]], 1);
          end
        end
        for (int o = 0; o < NumPorts; o++) begin
          if (data_v_o[o]) begin
            src = int'(data_o[o].payload[15:14]);
            vc  = int'(data_o[o].payload[13]);
            if (exp_q[src][vc][o].size() == 0) begin
              report_failure($sformatf("output %0d delivered a flit nobody sent", o));
            end
            exp = expected_flit(src, vc, exp_q[src][vc][o].pop_front(), o);
            check_value("data_o.payload", data_o[o].payload, exp.payload);
            check_value("data_o.dst_port", data_o[o].dst_port, exp.dst_port);
            check_value("credit_id_o", credit_id_o[src], vc);
            arr_src[src]++;
            // a repeat winner is wrong if another head had been waiting
            if (fair_mode && last_src[o] == src) begin
              for (int s = 0; s < NumPorts; s++) begin
                for (int v = 0; v < NumVc; v++) begin
                  if (s != src && exp_q[s][v][o].size() > 0) begin
                    key = int'(expected_flit(s, v, exp_q[s][v][o][0], o).payload);
                    if (in_time.exists(key) && in_time[key] <= cyc - 2) begin
                      report_failure($sformatf("input %0d granted twice while %0d waited",
                                               src, s));
                    end
                  end
                end
              end
            end
            last_src[o] = src;
            last_lat[o] = cyc - in_time[int'(data_o[o].payload)];
            check_value("downstream credit left", ds_cred[o][data_o[o].vc] > 0, 1);
            ds_cred[o][data_o[o].vc]--;
            ds_pend[o].push_back(int'(data_o[o].vc));
            vc_log[o].push_back(int'(data_o[o].vc));
            out_cnt[o]++;
            total_recv++;
          end
          if (credit_v_i[o]) begin
            ds_cred[o][credit_id_i[o]]++;
          end
        end
        // one credit pulse per delivered flit in the same cycle
        for (int p = 0; p < NumPorts; p++) begin
          check_value("credit_v_o", credit_v_o[p], arr_src[p]);
        end
        for (int o = 0; o < NumPorts; o++) begin
          if (!hold[o] && ds_pend[o].size() > 0 && (!jitter || $urandom_range(3) != 0)) begin
            credit_v_i[o]  <= 1'b1;
            credit_id_i[o] <= vc_router_pkg::vc_id_t'(ds_pend[o].pop_front());
          end else begin
            credit_v_i[o]  <= 1'b0;
          end
        end
      end
    end
  end

  // ==========================================================================
  // stimulus helpers
  // ==========================================================================

  task automatic send_flit(input int p, input int v, input int dst);
    int waited;
    waited = 0;
    @(posedge clk_i);
    while (sent[p][v] - returned[p][v] >= VcDepth) begin
      data_v_i[p] <= 1'b0;
      waited++;
      if (waited > Timeout) begin
        report_failure($sformatf("credit for input %0d vc %0d never came back", p, v));
      end
      @(posedge clk_i);
    end
    data_v_i[p] <= 1'b1;
    data_i[p]   <= expected_flit(p, v, seq_cnt[p][v], dst);
    exp_q[p][v][dst].push_back(seq_cnt[p][v]);
    seq_cnt[p][v]++;
    sent[p][v]++;
    total_sent++;
  endtask

  task automatic idle_port(input int p);
    @(posedge clk_i);
    data_v_i[p] <= 1'b0;
  endtask

  task automatic send_stream(input int p, input int dst, input int n);
    for (int k = 0; k < n; k++) begin
      send_flit(p, k % NumVc, dst);
    end
    idle_port(p);
  endtask

  task automatic send_random(input int p, input int n);
    int dst;
    for (int k = 0; k < n; k++) begin
      dst = $urandom_range(NumPorts - 2);
      if (dst >= p) begin
        dst++;
      end
      send_flit(p, $urandom_range(NumVc - 1), dst);
    end
    idle_port(p);
  endtask

  task automatic wait_output(input int o, input int n);
    int waited;
    waited = 0;
    while (out_cnt[o] < n) begin
      waited++;
      if (waited > Timeout) begin
        report_failure($sformatf("flit %0d on output %0d never arrived", n, o));
      end
      @(posedge clk_i);
    end
  endtask

  task automatic wait_drained();
    int waited;
    int home;
    waited = 0;
    home   = 0;
    while (total_recv != total_sent || !home) begin
      home = 1;
      for (int o = 0; o < NumPorts; o++) begin
        for (int v = 0; v < NumVc; v++) begin
          if (ds_cred[o][v] != VcDepth) begin
            home = 0;
          end
        end
      end
      waited++;
      if (waited > Timeout) begin
        report_failure($sformatf("%0d flits or their credits never came back",
                                 total_sent - total_recv));
      end
      @(posedge clk_i);
    end
  endtask

  // ==========================================================================
  // test sequence
  // ==========================================================================

  initial begin
    int base1;
    int base3;
    void'($urandom(90));
    arst_n_i    = 1'b0;
    data_v_i    = '0;
    data_i      = '0;
    hold        = '0;
    jitter      = 1'b0;
    fair_mode   = 1'b0;
    for (int o = 0; o < NumPorts; o++) begin
      last_src[o] = -1;
      for (int v = 0; v < NumVc; v++) begin
        ds_cred[o][v] = VcDepth;
      end
    end
    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;

    // single flits through an idle router
    for (int s = 0; s < NumPorts; s++) begin
      for (int d = 0; d < NumPorts; d++) begin
        if (d != s) begin
          base1 = out_cnt[d];
          send_flit(s, 0, d);
          idle_port(s);
          wait_output(d, base1 + 1);
          check_value("latency", last_lat[d], 2);
          check_value("data_o.vc", vc_log[d][base1], 0);
          wait_drained();
        end
      end
    end

    // output 1 starved of credits while output 3 keeps flowing
    hold[1] = 1'b1;
    base1   = out_cnt[1];
    base3   = out_cnt[3];
    fork
      send_stream(0, 1, 6);
      send_stream(2, 3, 8);
    join
    wait_output(3, base3 + 8);
    wait_output(1, base1 + NumVc * VcDepth);
    repeat (20) @(posedge clk_i);
    check_value("flits on blocked output", out_cnt[1] - base1, NumVc * VcDepth);
    for (int k = 0; k < NumVc * VcDepth; k++) begin
      check_value("data_o.vc", vc_log[1][base1 + k], k / VcDepth);
    end
    hold[1] = 1'b0;
    wait_drained();

    // three inputs competing for one output
    for (int o = 0; o < NumPorts; o++) begin
      last_src[o] = -1;
    end
    fair_mode = 1'b1;
    fork
      send_stream(0, 3, 12);
      send_stream(1, 3, 12);
      send_stream(2, 3, 12);
    join
    wait_drained();
    fair_mode = 1'b0;

    // random traffic with jittered downstream credits
    jitter = 1'b1;
    fork
      send_random(0, 600);
      send_random(1, 600);
      send_random(2, 600);
      send_random(3, 600);
    join
    jitter = 1'b0;
    wait_drained();
    for (int s = 0; s < NumPorts; s++) begin
      for (int v = 0; v < NumVc; v++) begin
        for (int d = 0; d < NumPorts; d++) begin
          check_value("flits still expected", exp_q[s][v][d].size(), 0);
        end
      end
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- vc_switch.sv
/*
 * sa to st stage register and the crossbar
 * each output forwards the flit of its granted input with the new vc
 */

`timescale 1ns/1ps

module vc_switch #(
  parameter int NumPorts = vc_router_pkg::DefaultNumPorts
) (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  // per output, one-hot over inputs
  input  logic [NumPorts-1:0][NumPorts-1:0]     grant_oh_i,
  input  vc_router_pkg::vc_id_t [NumPorts-1:0]  assigned_vc_i,
  // per input, the local winner
  input  vc_router_pkg::flit_t [NumPorts-1:0]   flits_i,
  output logic [NumPorts-1:0]                   data_v_o,
  output vc_router_pkg::flit_t [NumPorts-1:0]   data_o
);

  logic [NumPorts-1:0][NumPorts-1:0]    grant_q;
  vc_router_pkg::vc_id_t [NumPorts-1:0] vc_q;
  vc_router_pkg::flit_t [NumPorts-1:0]  flit_q;

  // ==========================================================================
  // stage register
  // ==========================================================================

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      grant_q <= '0;
    end else begin
      grant_q <= grant_oh_i;
    end
  end

  always_ff @(posedge clk_i) begin
    vc_q   <= assigned_vc_i;
    flit_q <= flits_i;
  end

  // ==========================================================================
  // crossbar
  // ==========================================================================

  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      data_v_o[o] = |grant_q[o];
      data_o[o]   = '0;
      for (int i = 0; i < NumPorts; i++) begin
        if (grant_q[o][i]) begin
          data_o[o] = flit_q[i];
        end
      end
      // downstream vc replaces the input vc
      data_o[o].vc = vc_q[o];
    end
  end

endmodule
